// ==== soc_fabric.f ====
hw/soc_bus_pkg.sv
hw/soc_map_pkg.sv
hw/mem_bus_if.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/simple_ram.sv
hw/gpio_regs.sv
hw/core_timer.sv
hw/soc_fabric.sv
bench/soc_fabric_table.sv
bench/soc_fabric_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
LINT_FLAGS = --lint-only --timing -Wall --timescale 1ns/10ps
TOP = soc_fabric_tb
FILELIST = soc_fabric.f
OBJ_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all build lint clean

all: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/soc_fabric_tb.sv ====
`timescale 1ns/10ps

module soc_fabric_tb;

	localparam int TIMEOUT = 50;

	logic clk_main = 1'b0;
	logic rst_n;
	logic [1:0] req;
	logic [1:0] gnt;
	logic [1:0] we;
	logic [1:0] rd;
	logic [1:0] ready;
	soc_bus_pkg::addr_t a [2];
	soc_bus_pkg::word_t d [2];
	soc_bus_pkg::word_t spo [2];
	logic [1:0] sw;
	logic [1:0] btn;
	logic [3:0] led;
	logic gpio_irq;
	logic timer_irq;
	logic soft_irq;

	soc_fabric_table_pkg::rnd_t rnd;
	soc_fabric_table_pkg::row_t rows [soc_fabric_table_pkg::N_ROWS];

	always #20 clk_main = ~clk_main;

	soc_fabric #(
		.MAIN_DEPTH_LOG2(soc_fabric_table_pkg::MAIN_DEPTH_LOG2),
		.SCRATCH_DEPTH_LOG2(soc_fabric_table_pkg::SCRATCH_DEPTH_LOG2),
		.TIMER_DIV(4)
	) soc_fabric_i (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.h0_req(req[0]),
		.h0_gnt(gnt[0]),
		.h0_a(a[0]),
		.h0_d(d[0]),
		.h0_we(we[0]),
		.h0_rd(rd[0]),
		.h0_spo(spo[0]),
		.h0_ready(ready[0]),
		.h1_req(req[1]),
		.h1_gnt(gnt[1]),
		.h1_a(a[1]),
		.h1_d(d[1]),
		.h1_we(we[1]),
		.h1_rd(rd[1]),
		.h1_spo(spo[1]),
		.h1_ready(ready[1]),
		.sw(sw),
		.btn(btn),
		.led(led),
		.gpio_irq(gpio_irq),
		.timer_irq(timer_irq),
		.soft_irq(soft_irq)
	);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input soc_bus_pkg::word_t actual,
		input soc_bus_pkg::word_t expected, input string msg);
		if (actual !== expected)
			fail_run($sformatf("mismatch at %0t ns: %s, got %h, expected %h",
				$time, msg, actual, expected));
	endtask

	function automatic soc_bus_pkg::addr_t reg_addr(input soc_bus_pkg::addr_t base,
		input soc_bus_pkg::addr_t off);
		return base + (off << 2);
	endfunction

	// grants may never overlap
	always @(negedge clk_main) begin
		if (rst_n)
			check_value(32'(gnt[0] && gnt[1]), 32'd0, "gnt0 and gnt1 high together");
	end

	task automatic raise_req(input int host);
		@(posedge clk_main);
		req[host] <= 1'b1;
	endtask

	task automatic wait_grant(input int host);
		int n = 0;
		do begin
			@(negedge clk_main);
			n++;
			if (n > TIMEOUT)
				fail_run($sformatf("timeout: gnt for host %0d never arrived", host));
		end while (!gnt[host]);
	endtask

	task automatic request_bus(input int host);
		raise_req(host);
		wait_grant(host);
	endtask

	task automatic release_bus(input int host);
		int n = 0;
		@(posedge clk_main);
		req[host] <= 1'b0;
		do begin
			@(negedge clk_main);
			n++;
			if (n > TIMEOUT)
				fail_run($sformatf("timeout: gnt for host %0d never dropped", host));
		end while (gnt[host]);
	endtask

	// one strobe, then ready must follow on the next cycle
	task automatic bus_access(input int host, input soc_fabric_table_pkg::op_t op,
		input soc_bus_pkg::addr_t addr, input soc_bus_pkg::word_t data,
		output soc_bus_pkg::word_t rdata);
		int n = 0;
		@(posedge clk_main);
		a[host] <= addr;
		d[host] <= data;
		we[host] <= (op == soc_fabric_table_pkg::OP_WRITE);
		rd[host] <= (op == soc_fabric_table_pkg::OP_READ);
		@(posedge clk_main);
		we[host] <= 1'b0;
		rd[host] <= 1'b0;
		do begin
			@(negedge clk_main);
			n++;
			if (n > TIMEOUT)
				fail_run($sformatf("timeout: ready for host %0d never arrived", host));
		end while (!ready[host]);
		check_value(n, 1, $sformatf("ready delay for address %h", addr));
		rdata = spo[host];
	endtask

	task automatic write_word(input int host, input soc_bus_pkg::addr_t addr,
		input soc_bus_pkg::word_t data);
		soc_bus_pkg::word_t unused;
		bus_access(host, soc_fabric_table_pkg::OP_WRITE, addr, data, unused);
	endtask

	task automatic read_expect(input int host, input soc_bus_pkg::addr_t addr,
		input soc_bus_pkg::word_t expected, input string msg);
		soc_bus_pkg::word_t rdata;
		bus_access(host, soc_fabric_table_pkg::OP_READ, addr, '0, rdata);
		check_value(rdata, expected, msg);
	endtask

	task automatic apply_rows(input int lo, input int hi);
		for (int i = lo; i < hi; i++) begin
			if (rows[i].op == soc_fabric_table_pkg::OP_WRITE)
				write_word(rows[i].host, rows[i].addr, rows[i].data);
			else
				read_expect(rows[i].host, rows[i].addr, rows[i].exp_data,
					$sformatf("table row %0d", i));
		end
	endtask

	task automatic set_inputs(input logic [1:0] sw_val, input logic [1:0] btn_val);
		@(posedge clk_main);
		sw <= sw_val;
		btn <= btn_val;
		@(negedge clk_main);
	endtask

	initial begin
		int n;
		soc_bus_pkg::word_t now;
		soc_bus_pkg::addr_t gpio_b;
		soc_bus_pkg::addr_t timer_b;
		gpio_b = soc_map_pkg::GPIO_BASE;
		timer_b = soc_map_pkg::TIMER_BASE;
		rst_n = 1'b0;
		req = '0;
		we = '0;
		rd = '0;
		a[0] = '0;
		a[1] = '0;
		d[0] = '0;
		d[1] = '0;
		sw = 2'b00;
		btn = 2'b00;
		void'($urandom(53));
		for (int i = 0; i < soc_fabric_table_pkg::N_RND; i++)
			rnd[i] = $urandom;
		for (int i = 0; i < soc_fabric_table_pkg::N_ROWS; i++)
			rows[i] = soc_fabric_table_pkg::table_row(i, rnd);

		repeat (4) @(posedge clk_main);
		rst_n <= 1'b1;
		@(negedge clk_main);
		check_value(32'(gnt), 32'd0, "gnt after reset");
		check_value(32'(led), 32'd0, "led after reset");
		check_value(32'({gpio_irq, timer_irq, soft_irq}), 32'd0, "irq after reset");

		request_bus(0);
		read_expect(0, reg_addr(timer_b, soc_map_pkg::TIMER_MTIMECMP), '1, "mtimecmp reset");

		// host 1 waits while host 0 runs its rows
		raise_req(1);
		apply_rows(0, soc_fabric_table_pkg::N_H0_ROWS);
		check_value(32'(gnt[1]), 32'd0, "gnt1 while host 0 holds the bus");
		release_bus(0);
		wait_grant(1);
		apply_rows(soc_fabric_table_pkg::N_H0_ROWS, soc_fabric_table_pkg::N_ROWS);
		release_bus(1);

		request_bus(0);
		write_word(0, reg_addr(gpio_b, soc_map_pkg::GPIO_LED), 32'h5);
		check_value(32'(led), 32'h5, "led after write");
		set_inputs(2'b10, 2'b01);
		read_expect(0, reg_addr(gpio_b, soc_map_pkg::GPIO_IN), 32'({2'b10, 2'b01}), "gpio in");
		check_value(32'(gpio_irq), 32'd0, "gpio_irq with enable clear");
		write_word(0, reg_addr(gpio_b, soc_map_pkg::GPIO_IRQ_EN), 32'd1);
		check_value(32'(gpio_irq), 32'd1, "gpio_irq with button held");
		set_inputs(2'b10, 2'b00);
		check_value(32'(gpio_irq), 32'd0, "gpio_irq with buttons released");

		// compare far ahead, then a few ticks ahead
		bus_access(0, soc_fabric_table_pkg::OP_READ,
			reg_addr(timer_b, soc_map_pkg::TIMER_MTIME), '0, now);
		write_word(0, reg_addr(timer_b, soc_map_pkg::TIMER_MTIMECMP), now + 32'd1000);
		check_value(32'(timer_irq), 32'd0, "timer_irq with mtimecmp far ahead");
		bus_access(0, soc_fabric_table_pkg::OP_READ,
			reg_addr(timer_b, soc_map_pkg::TIMER_MTIME), '0, now);
		write_word(0, reg_addr(timer_b, soc_map_pkg::TIMER_MTIMECMP), now + 32'd4);
		check_value(32'(timer_irq), 32'd0, "timer_irq just after mtimecmp write");
		n = 0;
		while (!timer_irq) begin
			@(negedge clk_main);
			n++;
			if (n > TIMEOUT)
				fail_run("timeout: timer_irq never rose after mtimecmp was written");
		end

		write_word(0, reg_addr(timer_b, soc_map_pkg::TIMER_MSIP), 32'd1);
		check_value(32'(soft_irq), 32'd1, "soft_irq after msip set");
		write_word(0, reg_addr(timer_b, soc_map_pkg::TIMER_MSIP), 32'd0);
		check_value(32'(soft_irq), 32'd0, "soft_irq after msip clear");
		release_bus(0);

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== bench/soc_fabric_table.sv ====
package soc_fabric_table_pkg;

	// memory sizes the testbench gives the DUT, in word address bits
	localparam int MAIN_DEPTH_LOG2 = 12;
	localparam int SCRATCH_DEPTH_LOG2 = 10;

	// one full scratch depth in bytes
	localparam soc_bus_pkg::addr_t SCRATCH_SPAN = 32'd1 << (SCRATCH_DEPTH_LOG2 + 2);

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} op_t;

	// one access and the word a read must return
	typedef struct packed {
		int host;
		op_t op;
		soc_bus_pkg::addr_t addr;
		soc_bus_pkg::word_t data;
		soc_bus_pkg::word_t exp_data;
	} row_t;

	localparam int N_RND = 6;
	localparam int N_ROWS = 16;
	// rows below this index belong to host 0, the rest to host 1
	localparam int N_H0_ROWS = 14;

	typedef soc_bus_pkg::word_t rnd_t [N_RND];

	function automatic row_t make_row(int host, op_t op, soc_bus_pkg::addr_t addr,
		soc_bus_pkg::word_t data, soc_bus_pkg::word_t exp_data);
		row_t r;
		r.host = host;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.exp_data = exp_data;
		return r;
	endfunction

	// columns: host, op, byte address, write data, expected read word
	function automatic row_t table_row(int idx, rnd_t rnd);
		soc_bus_pkg::addr_t m;
		soc_bus_pkg::addr_t s;
		m = soc_map_pkg::MAIN_BASE;
		s = soc_map_pkg::SCRATCH_BASE;
		case (idx)
			0: return make_row(0, OP_WRITE, m + 32'h10, rnd[0], '0);
			1: return make_row(0, OP_WRITE, m + 32'h3ffc, rnd[1], '0);
			2: return make_row(0, OP_WRITE, s + 32'h20, rnd[2], '0);
			3: return make_row(0, OP_WRITE, s + 32'hffc, rnd[3], '0);
			4: return make_row(0, OP_WRITE, s, rnd[4], '0);
			5: return make_row(0, OP_READ, m + 32'h10, '0, rnd[0]);
			6: return make_row(0, OP_READ, m + 32'h3ffc, '0, rnd[1]);
			7: return make_row(0, OP_READ, s + 32'h20, '0, rnd[2]);
			// same scratch word, one depth higher
			8: return make_row(0, OP_READ, s + SCRATCH_SPAN + 32'h20, '0, rnd[2]);
			9: return make_row(0, OP_READ, s + 32'hffc, '0, rnd[3]);
			// device field 0x92 and 0xa0 select nothing
			10: return make_row(0, OP_WRITE, 32'h9200_0000, rnd[5], '0);
			11: return make_row(0, OP_READ, 32'h9200_0000, '0, '0);
			12: return make_row(0, OP_READ, 32'ha000_0004, '0, '0);
			13: return make_row(0, OP_READ, s, '0, rnd[4]);
			14: return make_row(1, OP_READ, m + 32'h10, '0, rnd[0]);
			15: return make_row(1, OP_READ, s + 32'h20, '0, rnd[2]);
			default: return make_row(0, OP_READ, m, '0, '0);
		endcase
	endfunction

endpackage

// ==== hw/soc_fabric.sv ====
`timescale 1ns/10ps

module soc_fabric #(
	parameter int MAIN_DEPTH_LOG2 = 12,
	parameter int SCRATCH_DEPTH_LOG2 = 10,
	parameter int TIMER_DIV = 1000
) (
	input logic clk_main,
	input logic rst_n,

	input logic h0_req,
	output logic h0_gnt,
	input soc_bus_pkg::addr_t h0_a,
	input soc_bus_pkg::word_t h0_d,
	input logic h0_we,
	input logic h0_rd,
	output soc_bus_pkg::word_t h0_spo,
	output logic h0_ready,

	input logic h1_req,
	output logic h1_gnt,
	input soc_bus_pkg::addr_t h1_a,
	input soc_bus_pkg::word_t h1_d,
	input logic h1_we,
	input logic h1_rd,
	output soc_bus_pkg::word_t h1_spo,
	output logic h1_ready,

	input logic [1:0] sw,
	input logic [1:0] btn,
	output logic [3:0] led,
	output logic gpio_irq,
	output logic timer_irq,
	output logic soft_irq
);

	mem_bus_if h0_bus ();
	mem_bus_if h1_bus ();
	mem_bus_if shared_bus ();
	mem_bus_if main_bus ();
	mem_bus_if scratch_bus ();
	mem_bus_if gpio_bus ();
	mem_bus_if timer_bus ();

	// host ports into their segments
	assign h0_bus.a = h0_a;
	assign h0_bus.d = h0_d;
	assign h0_bus.we = h0_we;
	assign h0_bus.rd = h0_rd;
	assign h0_spo = h0_bus.spo;
	assign h0_ready = h0_bus.ready;

	assign h1_bus.a = h1_a;
	assign h1_bus.d = h1_d;
	assign h1_bus.we = h1_we;
	assign h1_bus.rd = h1_rd;
	assign h1_spo = h1_bus.spo;
	assign h1_ready = h1_bus.ready;

	bus_arbiter arb_i (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.req0(h0_req),
		.req1(h1_req),
		.gnt0(h0_gnt),
		.gnt1(h1_gnt),
		.h0(h0_bus.dev),
		.h1(h1_bus.dev),
		.bus(shared_bus.host)
	);

	addr_decoder dec_i (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.bus(shared_bus.dev),
		.main_m(main_bus.host),
		.scratch_m(scratch_bus.host),
		.gpio_m(gpio_bus.host),
		.timer_m(timer_bus.host)
	);

	simple_ram #(.DEPTH_LOG2(MAIN_DEPTH_LOG2)) main_ram_i (
		.clk_main(clk_main),
		.mem(main_bus.dev)
	);

	simple_ram #(.DEPTH_LOG2(SCRATCH_DEPTH_LOG2)) scratch_ram_i (
		.clk_main(clk_main),
		.mem(scratch_bus.dev)
	);

	gpio_regs gpio_i (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.mem(gpio_bus.dev),
		.sw(sw),
		.btn(btn),
		.led(led),
		.irq(gpio_irq)
	);

	core_timer #(.TIMER_DIV(TIMER_DIV)) timer_i (
		.clk_main(clk_main),
		.rst_n(rst_n),
		.mem(timer_bus.dev),
		.t_irq(timer_irq),
		.s_irq(soft_irq)
	);

endmodule

// ==== hw/core_timer.sv ====
`timescale 1ns/10ps

module core_timer #(
	parameter int TIMER_DIV = 1000
) (
	input logic clk_main,
	input logic rst_n,
	mem_bus_if.dev mem,
	output logic t_irq,
	output logic s_irq
);

	localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic tick;
	logic mtime_wr;
	soc_bus_pkg::word_t mtime;
	soc_bus_pkg::word_t mtimecmp;
	logic msip;

	// prescaler, one tick per TIMER_DIV cycles
	assign tick = (div_cnt == DIV_W'(TIMER_DIV - 1));

	always_ff @(posedge clk_main) begin
		if (!rst_n || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign mtime_wr = mem.we && (mem.a == soc_map_pkg::TIMER_MTIME);

	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			mtime <= '0;
			mtimecmp <= '1;
			msip <= 1'b0;
		end else begin
			// a software write wins over the tick
			if (mtime_wr)
				mtime <= mem.d;
			else if (tick)
				mtime <= mtime + 1'b1;
			if (mem.we && (mem.a == soc_map_pkg::TIMER_MTIMECMP))
				mtimecmp <= mem.d;
			if (mem.we && (mem.a == soc_map_pkg::TIMER_MSIP))
				msip <= mem.d[0];
		end
	end

	always_ff @(posedge clk_main) begin
		if (mem.rd) begin
			case (mem.a)
				soc_map_pkg::TIMER_MTIME: mem.spo <= mtime;
				soc_map_pkg::TIMER_MTIMECMP: mem.spo <= mtimecmp;
				soc_map_pkg::TIMER_MSIP: mem.spo <= {31'd0, msip};
				default: mem.spo <= '0;
			endcase
		end
	end

	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			mem.ready <= 1'b0;
		end else begin
			mem.ready <= mem.rd || mem.we;
		end
	end

	assign t_irq = (mtime >= mtimecmp);
	assign s_irq = msip;

	mtime_monotonic: assert property (
		@(posedge clk_main) disable iff (!rst_n)
		!$past(mtime_wr) |-> (mtime >= $past(mtime))
	);

endmodule

// ==== hw/gpio_regs.sv ====
`timescale 1ns/10ps

module gpio_regs (
	input logic clk_main,
	input logic rst_n,
	mem_bus_if.dev mem,
	input logic [1:0] sw,
	input logic [1:0] btn,
	output logic [3:0] led,
	output logic irq
);

	logic irq_en;

	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			led <= '0;
			irq_en <= 1'b0;
		end else if (mem.we) begin
			case (mem.a)
				soc_map_pkg::GPIO_LED: led <= mem.d[3:0];
				soc_map_pkg::GPIO_IRQ_EN: irq_en <= mem.d[0];
				default: ;
			endcase
		end
	end

	// readback, switches sit above buttons
	always_ff @(posedge clk_main) begin
		if (mem.rd) begin
			case (mem.a)
				soc_map_pkg::GPIO_LED: mem.spo <= {28'd0, led};
				soc_map_pkg::GPIO_IN: mem.spo <= {28'd0, sw, btn};
				soc_map_pkg::GPIO_IRQ_EN: mem.spo <= {31'd0, irq_en};
				default: mem.spo <= '0;
			endcase
		end
	end

	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			mem.ready <= 1'b0;
		end else begin
			mem.ready <= mem.rd || mem.we;
		end
	end

	// level irq while any button is held
	assign irq = irq_en && (|btn);

endmodule

// ==== hw/simple_ram.sv ====
`timescale 1ns/10ps

module simple_ram #(
	parameter int DEPTH_LOG2 = 10
) (
	input logic clk_main,
	mem_bus_if.dev mem
);

	soc_bus_pkg::word_t ram [2**DEPTH_LOG2];
	logic [DEPTH_LOG2-1:0] idx;

	// upper word address bits are dropped, so the array repeats
	assign idx = mem.a[DEPTH_LOG2-1:0];

	always_ff @(posedge clk_main) begin
		if (mem.we) begin
			ram[idx] <= mem.d;
		end
	end

	always_ff @(posedge clk_main) begin
		if (mem.rd) begin
			mem.spo <= ram[idx];
		end
	end

	// ready one cycle after any strobe
	always_ff @(posedge clk_main) begin
		mem.ready <= mem.rd || mem.we;
	end

endmodule

// ==== hw/addr_decoder.sv ====
`timescale 1ns/10ps

module addr_decoder (
	input logic clk_main,
	input logic rst_n,
	mem_bus_if.dev bus,
	mem_bus_if.host main_m,
	mem_bus_if.host scratch_m,
	mem_bus_if.host gpio_m,
	mem_bus_if.host timer_m
);

	localparam int DEV_W = soc_map_pkg::DEV_SEL_MSB - soc_map_pkg::DEV_SEL_LSB + 1;

	localparam logic [DEV_W-1:0] SCRATCH_ID =
		soc_map_pkg::SCRATCH_BASE[soc_map_pkg::DEV_SEL_MSB:soc_map_pkg::DEV_SEL_LSB];
	localparam logic [DEV_W-1:0] GPIO_ID =
		soc_map_pkg::GPIO_BASE[soc_map_pkg::DEV_SEL_MSB:soc_map_pkg::DEV_SEL_LSB];
	localparam logic [DEV_W-1:0] TIMER_ID =
		soc_map_pkg::TIMER_BASE[soc_map_pkg::DEV_SEL_MSB:soc_map_pkg::DEV_SEL_LSB];

	soc_map_pkg::tgt_t sel;
	soc_map_pkg::tgt_t sel_q;
	soc_bus_pkg::addr_t region_off;
	soc_bus_pkg::addr_t word_off;
	logic strobe;
	logic none_ready;

	assign strobe = bus.rd || bus.we;

	always_comb begin
		if (!bus.a[soc_map_pkg::MAIN_OFF_W]) begin
			sel = soc_map_pkg::TGT_MAIN;
		end else begin
			case (bus.a[soc_map_pkg::DEV_SEL_MSB:soc_map_pkg::DEV_SEL_LSB])
				SCRATCH_ID: sel = soc_map_pkg::TGT_SCRATCH;
				GPIO_ID: sel = soc_map_pkg::TGT_GPIO;
				TIMER_ID: sel = soc_map_pkg::TGT_TIMER;
				default: sel = soc_map_pkg::TGT_NONE;
			endcase
		end
	end

	// offset inside the selected region
	always_comb begin
		region_off = '0;
		if (sel == soc_map_pkg::TGT_MAIN) begin
			region_off = bus.a - soc_map_pkg::MAIN_BASE;
		end else begin
			region_off[soc_map_pkg::MMIO_OFF_W-1:0] = bus.a[soc_map_pkg::MMIO_OFF_W-1:0];
		end
	end

	assign word_off = soc_bus_pkg::word_addr(region_off);

	assign main_m.a = word_off;
	assign scratch_m.a = word_off;
	assign gpio_m.a = word_off;
	assign timer_m.a = word_off;
	assign main_m.d = bus.d;
	assign scratch_m.d = bus.d;
	assign gpio_m.d = bus.d;
	assign timer_m.d = bus.d;

	// strobes reach the selected target only
	assign main_m.rd = bus.rd && (sel == soc_map_pkg::TGT_MAIN);
	assign main_m.we = bus.we && (sel == soc_map_pkg::TGT_MAIN);
	assign scratch_m.rd = bus.rd && (sel == soc_map_pkg::TGT_SCRATCH);
	assign scratch_m.we = bus.we && (sel == soc_map_pkg::TGT_SCRATCH);
	assign gpio_m.rd = bus.rd && (sel == soc_map_pkg::TGT_GPIO);
	assign gpio_m.we = bus.we && (sel == soc_map_pkg::TGT_GPIO);
	assign timer_m.rd = bus.rd && (sel == soc_map_pkg::TGT_TIMER);
	assign timer_m.we = bus.we && (sel == soc_map_pkg::TGT_TIMER);

	// remembered target steers the response; unmapped space answers by itself
	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			sel_q <= soc_map_pkg::TGT_NONE;
			none_ready <= 1'b0;
		end else begin
			sel_q <= sel;
			none_ready <= strobe && (sel == soc_map_pkg::TGT_NONE);
		end
	end

	always_comb begin
		case (sel_q)
			soc_map_pkg::TGT_MAIN: begin
				bus.spo = main_m.spo;
				bus.ready = main_m.ready;
			end
			soc_map_pkg::TGT_SCRATCH: begin
				bus.spo = scratch_m.spo;
				bus.ready = scratch_m.ready;
			end
			soc_map_pkg::TGT_GPIO: begin
				bus.spo = gpio_m.spo;
				bus.ready = gpio_m.ready;
			end
			soc_map_pkg::TGT_TIMER: begin
				bus.spo = timer_m.spo;
				bus.ready = timer_m.ready;
			end
			default: begin
				bus.spo = '0;
				bus.ready = none_ready;
			end
		endcase
	end

	// only the addressed target may answer
	one_responder: assert property (
		@(posedge clk_main) disable iff (!rst_n)
		$onehot0({main_m.ready, scratch_m.ready, gpio_m.ready, timer_m.ready,
			none_ready})
	);

	// every target and the unmapped responder answer on the next cycle
	strobe_gets_ready: assert property (
		@(posedge clk_main) disable iff (!rst_n)
		strobe |=> bus.ready
	);

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
	input logic clk_main,
	input logic rst_n,
	input logic req0,
	input logic req1,
	output logic gnt0,
	output logic gnt1,
	mem_bus_if.dev h0,
	mem_bus_if.dev h1,
	mem_bus_if.host bus
);

	soc_bus_pkg::host_sel_t owner;
	logic busy;
	logic owner_req;

	assign owner_req = (owner == soc_bus_pkg::HOST_1) ? req1 : req0;

	// fixed priority on an idle bus and held until the owner lets go
	always_ff @(posedge clk_main) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner <= soc_bus_pkg::HOST_0;
		end else if (!busy) begin
			if (req0) begin
				busy <= 1'b1;
				owner <= soc_bus_pkg::HOST_0;
			end else if (req1) begin
				busy <= 1'b1;
				owner <= soc_bus_pkg::HOST_1;
			end
		end else if (!owner_req) begin
			busy <= 1'b0;
		end
	end

	assign gnt0 = busy && (owner == soc_bus_pkg::HOST_0);
	assign gnt1 = busy && (owner == soc_bus_pkg::HOST_1);

	// winner onto the shared segment
	assign bus.a = gnt1 ? h1.a : h0.a;
	assign bus.d = gnt1 ? h1.d : h0.d;
	assign bus.we = (gnt0 && h0.we) || (gnt1 && h1.we);
	assign bus.rd = (gnt0 && h0.rd) || (gnt1 && h1.rd);

	// owner only changes a cycle after release and still names
	// the host whose last strobe is being answered
	assign h0.spo = (owner == soc_bus_pkg::HOST_0) ? bus.spo : '0;
	assign h1.spo = (owner == soc_bus_pkg::HOST_1) ? bus.spo : '0;
	assign h0.ready = bus.ready && (owner == soc_bus_pkg::HOST_0);
	assign h1.ready = bus.ready && (owner == soc_bus_pkg::HOST_1);

	// a grant stays put while its request is held
	gnt_held: assert property (
		@(posedge clk_main) disable iff (!rst_n)
		(gnt0 && req0) || (gnt1 && req1) |=> $stable({gnt0, gnt1})
	);

	gnt0_needs_req: assert property (
		@(posedge clk_main) disable iff (!rst_n)
		$rose(gnt0) |-> $past(req0)
	);

	gnt1_needs_req: assert property (
		@(posedge clk_main) disable iff (!rst_n)
		$rose(gnt1) |-> $past(req1)
	);

endmodule

// ==== hw/mem_bus_if.sv ====
`timescale 1ns/10ps

// one bus segment, strobes out and a one cycle ready back
interface mem_bus_if;

	soc_bus_pkg::addr_t a;
	soc_bus_pkg::word_t d;
	logic we;
	logic rd;
	soc_bus_pkg::word_t spo;
	logic ready;

	// side that issues accesses
	modport host (
		output a, d, we, rd,
		input spo, ready
	);

	// side that answers them
	modport dev (
		input a, d, we, rd,
		output spo, ready
	);

endinterface

// ==== hw/soc_map_pkg.sv ====
package soc_map_pkg;

	// region bases, main memory is everything below bit 31
	localparam soc_bus_pkg::addr_t MAIN_BASE = 32'h0000_0000;
	localparam soc_bus_pkg::addr_t SCRATCH_BASE = 32'h8000_0000;
	localparam soc_bus_pkg::addr_t GPIO_BASE = 32'h9000_0000;
	localparam soc_bus_pkg::addr_t TIMER_BASE = 32'h9100_0000;

	// bit that splits main memory from mmio space
	localparam int MAIN_OFF_W = 31;

	// device select field inside mmio space
	localparam int DEV_SEL_MSB = 31;
	localparam int DEV_SEL_LSB = 24;
	localparam int MMIO_OFF_W = DEV_SEL_LSB;

	// gpio word offsets
	localparam soc_bus_pkg::addr_t GPIO_LED = 32'd0;
	localparam soc_bus_pkg::addr_t GPIO_IN = 32'd1;
	localparam soc_bus_pkg::addr_t GPIO_IRQ_EN = 32'd2;

	// timer word offsets
	localparam soc_bus_pkg::addr_t TIMER_MTIME = 32'd0;
	localparam soc_bus_pkg::addr_t TIMER_MTIMECMP = 32'd1;
	localparam soc_bus_pkg::addr_t TIMER_MSIP = 32'd2;

	typedef enum logic [2:0] {
		TGT_MAIN, TGT_SCRATCH, TGT_GPIO, TGT_TIMER, TGT_NONE
	} tgt_t;

endpackage

// ==== hw/soc_bus_pkg.sv ====
package soc_bus_pkg;

	// width of one bus word and of a byte address
	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;

	// byte lane bits below the word index
	localparam int BYTE_OFF_W = 2;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// bus owner as seen by the arbiter
	typedef enum logic {
		HOST_0 = 1'b0,
		HOST_1 = 1'b1
	} host_sel_t;

	// byte address to word index, targets see word addresses only
	function automatic addr_t word_addr(addr_t byte_addr);
		addr_t idx;
		idx = '0;
		idx[ADDR_W-BYTE_OFF_W-1:0] = byte_addr[ADDR_W-1:BYTE_OFF_W];
		return idx;
	endfunction

endpackage
